//--- common/cdi_load_pkg.sv
package cdi_load_pkg;

    // ========================================================================
    // Host download word
    // ========================================================================

    localparam int HOST_INDEX_W = 16;
    localparam int HOST_ADDR_W  = 25;
    localparam int HOST_DATA_W  = 16;

    // One host write strobe with its image index, byte address and data
    typedef struct packed {
        logic                    wr;
        logic [HOST_INDEX_W-1:0] index;
        logic [HOST_ADDR_W-1:0]  addr;
        logic [HOST_DATA_W-1:0]  data;
    } host_word_t;

    // ========================================================================
    // Image selection
    // ========================================================================

    // Index bits 7:6 tell which boot image is being sent
    localparam int IMAGE_SEL_LSB = 6;
    localparam int IMAGE_SEL_W   = 2;

    // Index bit 7 also selects the VMPEG half of the ROM region
    localparam int VMPEG_BANK_BIT = 7;

    typedef enum logic [IMAGE_SEL_W-1:0] {
        IMG_MAIN_ROM   = 2'b00,
        IMG_SLAVE_WORM = 2'b01,
        IMG_VMPEG_WORM = 2'b10
    } image_kind_e;

    function automatic image_kind_e image_kind(input logic [HOST_INDEX_W-1:0] index);
        return image_kind_e'(index[IMAGE_SEL_LSB +: IMAGE_SEL_W]);
    endfunction

endpackage

//--- common/cdi_mem_pkg.sv
package cdi_mem_pkg;

    localparam int SDRAM_ADDR_W = 25;
    localparam int SDRAM_DATA_W = 16;
    localparam int WORM_ADDR_W  = 13;

    // Word counter for clearing, 512k words fit with room for the end value
    localparam int CLEAR_ADDR_W = 20;

    // Upper address bits where main and VMPEG ROM images live
    localparam logic [4:0] ROM_REGION = 5'b00100;

    // One request on the SDRAM controller port
    typedef struct packed {
        logic [SDRAM_ADDR_W-1:0] addr;
        logic [SDRAM_DATA_W-1:0] din;
        logic                    rd;
        logic                    wr;
        logic                    word;
        logic                    refresh;
        logic                    burst;
    } sdram_req_t;

    localparam sdram_req_t SDRAM_REQ_IDLE = '0;

    // Listed from highest to lowest priority
    typedef enum logic [1:0] {
        OWN_ROM,
        OWN_CLEAR,
        OWN_REFRESH,
        OWN_IDLE
    } sdram_owner_e;

    // Byte write into the slave write-once memory
    typedef struct packed {
        logic [WORM_ADDR_W-1:0] addr;
        logic [7:0]             data;
        logic                   wr;
    } worm_wr_t;

endpackage

//--- design/loader/image_router.sv
`timescale 1ns/1ps

module image_router (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_load_pkg::host_word_t host,
    output logic                     rom_strobe,
    output cdi_mem_pkg::worm_wr_t    worm
);

    cdi_load_pkg::image_kind_e               kind;
    logic                                    slave_strobe;
    logic                                    slave_strobe_q;
    logic                                    worm_wr_q;
    logic [cdi_mem_pkg::WORM_ADDR_W-1:0]     worm_addr_q;
    logic [7:0]                              worm_data_q;
    logic [7:0]                              high_byte_q;

    assign kind = cdi_load_pkg::image_kind(host.index);

    assign slave_strobe = host.wr && (kind == cdi_load_pkg::IMG_SLAVE_WORM);

    // Main ROM and VMPEG words both go to SDRAM
    assign rom_strobe = host.wr && (kind == cdi_load_pkg::IMG_MAIN_ROM ||
                                    kind == cdi_load_pkg::IMG_VMPEG_WORM);

    // ========================================================================
    // Slave write-once memory, one 16-bit word becomes two byte writes
    // ========================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            slave_strobe_q <= 1'b0;
            worm_wr_q      <= 1'b0;
        end else begin
            slave_strobe_q <= slave_strobe;
            // Low byte on the first cycle, high byte on the second
            worm_wr_q      <= slave_strobe || slave_strobe_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (slave_strobe) begin
            // A new word takes the slot even if a high byte was due
            worm_addr_q <= host.addr[cdi_mem_pkg::WORM_ADDR_W-1:0];
            worm_data_q <= host.data[7:0];
            high_byte_q <= host.data[15:8];
        end else begin
            worm_addr_q[0] <= 1'b1;
            worm_data_q    <= high_byte_q;
        end
    end

    assign worm = '{addr: worm_addr_q, data: worm_data_q, wr: worm_wr_q};

endmodule

//--- design/loader/rom_write_latch.sv
`timescale 1ns/1ps

module rom_write_latch (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_load_pkg::host_word_t host,
    input  logic                     rom_strobe,
    input  logic                     rom_done,
    output logic                     pending,
    output cdi_mem_pkg::sdram_req_t  rom_req,
    output logic                     overflow
);

    logic        vmpeg_q;
    logic [17:0] word_addr_q;
    logic [15:0] data_q;

    // ========================================================================
    // Pending flag and overflow
    // ========================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            pending  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (rom_strobe) begin
                pending <= 1'b1;
            end else if (rom_done) begin
                pending <= 1'b0;
            end

            // Host has no back-pressure, so a second word here is lost
            if (rom_strobe && pending) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rom_strobe) begin
            vmpeg_q     <= host.index[cdi_load_pkg::VMPEG_BANK_BIT];
            word_addr_q <= host.addr[18:1];
            data_q      <= host.data;
        end
    end

    // ========================================================================
    // SDRAM request for the held word
    // ========================================================================

    always_comb begin
        rom_req      = cdi_mem_pkg::SDRAM_REQ_IDLE;
        rom_req.addr = {cdi_mem_pkg::ROM_REGION, vmpeg_q, word_addr_q, 1'b0};
        // Host sends little endian, the 68k reads big endian
        rom_req.din  = {data_q[7:0], data_q[15:8]};
        rom_req.wr   = 1'b1;
        rom_req.word = 1'b1;
    end

endmodule

//--- design/core_reset_gen.sv
`timescale 1ns/1ps

module core_reset_gen #(
    parameter int clear_words = 524288
) (
    input  logic                                 clk_sys,
    input  logic                                 cditop_reset,
    input  logic                                 menu_reset,
    input  logic                                 download,
    input  logic                                 clear_step,
    output logic [cdi_mem_pkg::CLEAR_ADDR_W-1:0] clear_addr,
    output logic                                 clear_done,
    output logic                                 core_reset
);

    localparam logic [cdi_mem_pkg::CLEAR_ADDR_W-1:0] clear_end =
        cdi_mem_pkg::CLEAR_ADDR_W'(clear_words);

    logic download_q;

    assign clear_done = (clear_addr == clear_end);

    // ========================================================================
    // Clear counter and core reset hold
    // ========================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            download_q <= 1'b0;
            // Nothing to clear until a download starts
            clear_addr <= clear_end;
            core_reset <= 1'b1;
        end else begin
            download_q <= download;

            if (download && !download_q) begin
                clear_addr <= '0;
            end else if (clear_step && !clear_done) begin
                clear_addr <= clear_addr + 1'b1;
            end

            core_reset <= menu_reset || download || !clear_done;
        end
    end

endmodule

//--- design/sdram_prep_arbiter.sv
`timescale 1ns/1ps

module sdram_prep_arbiter #(
    parameter int clear_words = 524288
) (
    input  logic                                 clk_sys,
    input  logic                                 cditop_reset,
    input  logic                                 core_reset,
    input  logic                                 pending,
    input  cdi_mem_pkg::sdram_req_t              rom_req,
    input  logic [cdi_mem_pkg::CLEAR_ADDR_W-1:0] clear_addr,
    input  logic                                 clear_done,
    input  cdi_mem_pkg::sdram_req_t              core_req,
    input  logic                                 sdram_busy,
    output cdi_mem_pkg::sdram_req_t              sdram,
    output logic                                 rom_done,
    output logic                                 clear_step
);

    // An empty clear region never takes the port
    localparam bit clear_enabled = (clear_words > 0);
    localparam int clear_pad_w = cdi_mem_pkg::SDRAM_ADDR_W - cdi_mem_pkg::CLEAR_ADDR_W - 1;

    cdi_mem_pkg::sdram_owner_e owner_next;
    cdi_mem_pkg::sdram_owner_e owner;
    cdi_mem_pkg::sdram_owner_e owner_q;
    cdi_mem_pkg::sdram_req_t   prep_req;
    logic                      busy_q;
    logic                      op_done;

    // ========================================================================
    // Owner selection
    // ========================================================================

    always_comb begin
        owner_next = cdi_mem_pkg::OWN_IDLE;
        if (core_reset) begin
            if (pending) begin
                owner_next = cdi_mem_pkg::OWN_ROM;
            end else if (clear_enabled && !clear_done) begin
                owner_next = cdi_mem_pkg::OWN_CLEAR;
            end else begin
                owner_next = cdi_mem_pkg::OWN_REFRESH;
            end
        end
    end

    // Owner stays put until the running operation is over
    assign owner = sdram_busy ? owner_q : owner_next;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q <= cdi_mem_pkg::OWN_IDLE;
            // Port looks busy so nothing is issued until a cycle after reset
            busy_q  <= 1'b1;
        end else begin
            owner_q <= owner;
            busy_q  <= sdram_busy;
        end
    end

    // Falling edge of busy ends the operation of the registered owner
    assign op_done    = busy_q && !sdram_busy;
    assign rom_done   = op_done && (owner_q == cdi_mem_pkg::OWN_ROM);
    assign clear_step = op_done && (owner_q == cdi_mem_pkg::OWN_CLEAR);

    // ========================================================================
    // Preparation request
    // ========================================================================

    always_comb begin
        prep_req      = cdi_mem_pkg::SDRAM_REQ_IDLE;
        prep_req.word = 1'b1;
        // Word counter to byte address
        prep_req.addr = {{clear_pad_w{1'b0}}, clear_addr, 1'b0};

        case (owner)
            cdi_mem_pkg::OWN_ROM: begin
                prep_req = rom_req;
            end
            cdi_mem_pkg::OWN_CLEAR: begin
                prep_req.wr = 1'b1;
            end
            cdi_mem_pkg::OWN_REFRESH: begin
                prep_req.rd      = 1'b1;
                prep_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase

        // Nothing new until the cycle after busy has fallen,
        // so the finishing owner can update its state first
        if (sdram_busy || busy_q) begin
            prep_req.rd      = 1'b0;
            prep_req.wr      = 1'b0;
            prep_req.refresh = 1'b0;
        end
    end

    // Core owns the port once its reset is released
    assign sdram = core_reset ? prep_req : core_req;

endmodule

//--- design/cdi_loader_top.sv
`timescale 1ns/1ps

module cdi_loader_top #(
    parameter int clear_words = 524288
) (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_load_pkg::host_word_t host,
    input  logic                     download,
    input  logic                     menu_reset,
    input  cdi_mem_pkg::sdram_req_t  core_req,
    input  logic                     sdram_busy,
    output cdi_mem_pkg::sdram_req_t  sdram,
    output cdi_mem_pkg::worm_wr_t    worm,
    output logic                     core_reset,
    output logic                     overflow
);

    logic                                 rom_strobe;
    logic                                 rom_done;
    logic                                 pending;
    cdi_mem_pkg::sdram_req_t              rom_req;
    logic [cdi_mem_pkg::CLEAR_ADDR_W-1:0] clear_addr;
    logic                                 clear_done;
    logic                                 clear_step;

    image_router u_image_router (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .host         (host),
        .rom_strobe   (rom_strobe),
        .worm         (worm)
    );

    rom_write_latch u_rom_write_latch (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .host         (host),
        .rom_strobe   (rom_strobe),
        .rom_done     (rom_done),
        .pending      (pending),
        .rom_req      (rom_req),
        .overflow     (overflow)
    );

    core_reset_gen #(
        .clear_words (clear_words)
    ) u_core_reset_gen (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .menu_reset   (menu_reset),
        .download     (download),
        .clear_step   (clear_step),
        .clear_addr   (clear_addr),
        .clear_done   (clear_done),
        .core_reset   (core_reset)
    );

    sdram_prep_arbiter #(
        .clear_words (clear_words)
    ) u_sdram_prep_arbiter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .core_reset   (core_reset),
        .pending      (pending),
        .rom_req      (rom_req),
        .clear_addr   (clear_addr),
        .clear_done   (clear_done),
        .core_req     (core_req),
        .sdram_busy   (sdram_busy),
        .sdram        (sdram),
        .rom_done     (rom_done),
        .clear_step   (clear_step)
    );

endmodule

//--- testbench/tb_cdi_loader_assertions.sv
`timescale 1ns/1ps

module cdi_loader_assertions (
    input logic                      clk_sys,
    input logic                      cditop_reset,
    input logic                      core_reset,
    input logic                      pending,
    input logic                      sdram_busy,
    input cdi_mem_pkg::sdram_req_t   sdram,
    input cdi_mem_pkg::sdram_owner_e owner
);

    // Number of assertion failures so far
    int failures = 0;

    // Only checked while preparing since the core drives the port otherwise
    no_op_while_busy: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        (core_reset && sdram_busy) |-> !(sdram.rd || sdram.wr))
        else begin
            $error("read or write presented while SDRAM is busy");
            failures = failures + 1;
        end

    no_write_with_refresh: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !(sdram.wr && sdram.refresh))
        else begin
            $error("write and refresh presented together");
            failures = failures + 1;
        end

    rom_write_needs_pending: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        (core_reset && sdram.wr && owner == cdi_mem_pkg::OWN_ROM) |-> pending)
        else begin
            $error("ROM write presented without a pending word");
            failures = failures + 1;
        end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                    clk_sys,
    input  logic                    start,
    input  int                      test_num,
    input  logic [7:0]              kind,
    input  logic [31:0]             exp_a,
    input  logic [31:0]             exp_b,
    input  cdi_mem_pkg::sdram_req_t sdram,
    input  cdi_mem_pkg::sdram_req_t core_req,
    input  cdi_mem_pkg::worm_wr_t   worm,
    input  logic                    core_reset,
    input  logic                    pending,
    input  logic                    overflow,
    output int                      tests_done,
    output int                      tests_failed,
    output int                      errors
);

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            $display("[ERROR] test %0d %s: got 0x%0h, expected 0x%0h",
                     test_num, name, got, expected);
            errors = errors + 1;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Test %0d: %s", test_num, what);
        errors = errors + 1;
    endtask

    // ========================================================================
    // Checks per test kind sampled on the falling edge
    // ========================================================================

    task automatic check_reset_state;
        compare_value("sdram.rd", sdram.rd, 1'b0);
        compare_value("sdram.wr", sdram.wr, 1'b0);
        compare_value("sdram.refresh", sdram.refresh, 1'b0);
        compare_value("worm.wr", worm.wr, 1'b0);
        compare_value("pending", pending, 1'b0);
        compare_value("overflow", overflow, 1'b0);
        compare_value("core_reset", core_reset, 1'b1);
    endtask

    task automatic check_rom_write;
        int writes;
        writes = 0;
        // Done once the write was seen and pending has dropped again
        while (writes == 0 || pending) begin
            @(negedge clk_sys);
            if (sdram.wr) begin
                writes = writes + 1;
                if (writes == 1) begin
                    compare_value("sdram.addr", sdram.addr, exp_a);
                    compare_value("sdram.din", sdram.din, exp_b);
                    compare_value("sdram.word", sdram.word, 1'b1);
                end
            end
        end
        compare_value("rom write count", writes, 1);
    endtask

    task automatic check_slave_word;
        int stage;
        stage = 0;
        while (stage < 2) begin
            @(negedge clk_sys);
            if (sdram.wr || pending) begin
                report_problem("slave word reached the SDRAM path");
            end
            if (stage == 1) begin
                if (!worm.wr) begin
                    report_problem("high byte write did not follow the low byte");
                end
                compare_value("worm high byte", {worm.addr, worm.data}, exp_b);
                stage = 2;
            end else if (worm.wr) begin
                compare_value("worm low byte", {worm.addr, worm.data}, exp_a);
                stage = 1;
            end
        end
    endtask

    task automatic check_clear;
        int writes;
        bit refreshed;
        writes    = 0;
        refreshed = 1'b0;
        while (!refreshed) begin
            @(negedge clk_sys);
            if (sdram.wr) begin
                compare_value("sdram.addr", sdram.addr, writes * 2);
                compare_value("sdram.din", sdram.din, exp_b);
                writes = writes + 1;
            end else if (writes > 0 && sdram.rd && sdram.refresh) begin
                refreshed = 1'b1;
            end
        end
        compare_value("clear write count", writes, exp_a);
        compare_value("core_reset", core_reset, 1'b1);
    endtask

    task automatic check_overflow;
        bit seen;
        seen = 1'b0;
        while (!seen || pending) begin
            @(negedge clk_sys);
            if (pending) begin
                seen = 1'b1;
            end
        end
        compare_value("overflow", overflow, exp_a[0]);
    endtask

    task automatic check_release;
        while (core_reset) begin
            @(negedge clk_sys);
        end
        compare_value("sdram", sdram, core_req);
        compare_value("sdram.addr", sdram.addr, exp_a);
        compare_value("sdram.din", sdram.din, exp_b);
    endtask

    initial begin
        int errors_before;
        tests_done   = 0;
        tests_failed = 0;
        errors       = 0;
        forever begin
            @(negedge clk_sys);
            if (start) begin
                errors_before = errors;
                case (kind)
                    8'h0: check_reset_state();
                    8'h1: check_rom_write();
                    8'h2: check_slave_word();
                    8'h3: check_clear();
                    8'h4: check_release();
                    8'h5: check_overflow();
                    default: report_problem("unknown test kind in the data file");
                endcase
                if (errors == errors_before) begin
                    $display("test %0d kind %0d passed", test_num, kind);
                end else begin
                    $display("test %0d kind %0d failed", test_num, kind);
                    tests_failed = tests_failed + 1;
                end
                tests_done = tests_done + 1;
            end
        end
    end

endmodule

//--- testbench/tb_cdi_loader.sv
`timescale 1ns/1ps

module tb_cdi_loader;

    localparam int          clear_words = 16;
    localparam int          max_tests   = 32;
    localparam int          fields      = 6;
    localparam logic [31:0] end_kind    = 32'hff;

    logic                     clk_sys;
    logic                     cditop_reset;
    cdi_load_pkg::host_word_t host;
    logic                     download;
    logic                     menu_reset;
    cdi_mem_pkg::sdram_req_t  core_req;
    logic                     sdram_busy = 1'b0;
    cdi_mem_pkg::sdram_req_t  sdram;
    cdi_mem_pkg::worm_wr_t    worm;
    logic                     core_reset;
    logic                     overflow;

    logic        chk_start;
    int          chk_num;
    logic [7:0]  chk_kind;
    logic [31:0] chk_exp_a;
    logic [31:0] chk_exp_b;
    int          tests_done;
    int          tests_failed;
    int          errors;

    // Six fields per test of kind, index, address, data, expected a and expected b
    logic [31:0] test_mem [0:max_tests*fields-1];
    int          test_count = 0;
    int          busy_left;
    int          seed = 62559;

    cdi_loader_top #(
        .clear_words (clear_words)
    ) u_dut (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .host         (host),
        .download     (download),
        .menu_reset   (menu_reset),
        .core_req     (core_req),
        .sdram_busy   (sdram_busy),
        .sdram        (sdram),
        .worm         (worm),
        .core_reset   (core_reset),
        .overflow     (overflow)
    );

    tb_checker u_checker (
        .clk_sys      (clk_sys),
        .start        (chk_start),
        .test_num     (chk_num),
        .kind         (chk_kind),
        .exp_a        (chk_exp_a),
        .exp_b        (chk_exp_b),
        .sdram        (sdram),
        .core_req     (core_req),
        .worm         (worm),
        .core_reset   (core_reset),
        .pending      (u_dut.pending),
        .overflow     (overflow),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .errors       (errors)
    );

    bind sdram_prep_arbiter cdi_loader_assertions u_assertions (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .core_reset   (core_reset),
        .pending      (pending),
        .sdram_busy   (sdram_busy),
        .sdram        (sdram),
        .owner        (owner)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // ========================================================================
    // SDRAM busy model
    // ========================================================================

    // Each accepted operation keeps the port busy for 1 to 4 cycles
    always @(posedge clk_sys) begin
        if (cditop_reset) begin
            sdram_busy <= 1'b0;
            busy_left  <= 0;
        end else if (busy_left > 0) begin
            if (busy_left == 1) begin
                sdram_busy <= 1'b0;
            end
            busy_left <= busy_left - 1;
        end else if (sdram.rd || sdram.wr) begin
            sdram_busy <= 1'b1;
            busy_left  <= 1 + ($unsigned($random(seed)) % 4);
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic run_test(input int n);
        logic [31:0] kind;
        logic [31:0] index;
        logic [31:0] addr;
        logic [31:0] data;
        kind  = test_mem[n*fields];
        index = test_mem[n*fields+1];
        addr  = test_mem[n*fields+2];
        data  = test_mem[n*fields+3];
        // Reset is released on the third rising edge
        if (kind == 32'h0) begin
            repeat (2) @(posedge clk_sys);
        end
        @(posedge clk_sys);
        chk_num   <= n;
        chk_kind  <= kind[7:0];
        chk_exp_a <= test_mem[n*fields+4];
        chk_exp_b <= test_mem[n*fields+5];
        chk_start <= 1'b1;
        case (kind)
            32'h0: cditop_reset <= 1'b0;
            32'h1, 32'h2, 32'h5: begin
                host <= '{wr: 1'b1, index: index[15:0], addr: addr[24:0], data: data[15:0]};
            end
            32'h3: download <= 1'b1;
            32'h4: begin
                download   <= 1'b0;
                menu_reset <= 1'b0;
                core_req   <= '{addr: addr[24:0], din: data[15:0], rd: 1'b0, wr: 1'b1,
                                word: 1'b1, refresh: 1'b0, burst: 1'b0};
            end
            default: begin
            end
        endcase
        @(posedge clk_sys);
        chk_start <= 1'b0;
        // Overflow test sends the word again on the next cycle
        if (kind != 32'h5) begin
            host.wr <= 1'b0;
        end
        @(posedge clk_sys);
        host.wr <= 1'b0;
        wait (tests_done == n + 1);
    endtask

    initial begin
        cditop_reset = 1'b1;
        host         = '0;
        download     = 1'b0;
        menu_reset   = 1'b1;
        core_req     = '0;
        chk_start    = 1'b0;
        chk_num      = 0;
        chk_kind     = '0;
        chk_exp_a    = '0;
        chk_exp_b    = '0;
        $readmemh("testbench/loader_tests.txt", test_mem);
        while (test_count < max_tests && test_mem[test_count*fields] != end_kind) begin
            test_count = test_count + 1;
        end
        for (int n = 0; n < test_count; n++) begin
            run_test(n);
        end
        @(posedge clk_sys);
        $display("Summary: %0d tests run, %0d tests failed, %0d errors, %0d assertion failures",
                 tests_done, tests_failed, errors,
                 u_dut.u_sdram_prep_arbiter.u_assertions.failures);
        if (test_count > 0 && errors == 0 &&
            u_dut.u_sdram_prep_arbiter.u_assertions.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog scaled by the number of tests in the data file
    initial begin
        wait (test_count > 0);
        repeat (test_count * 200 + 500) @(posedge clk_sys);
        $display("Timeout: tests did not finish within %0d cycles", test_count * 200 + 500);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- testbench/loader_tests.txt
// kind index address data expected_a expected_b, all hex
// kinds: 0 reset, 1 rom word, 2 slave word, 3 clear, 4 core release, 5 overflow, ff end
0 0000 0000000 0000 00000000 00000000
3 0000 0000000 0000 00000010 00000000
1 0000 0000124 1234 00400124 00003412
1 0080 00003a6 beef 004803a6 0000efbe
1 0000 01a0011 a55a 00420010 00005aa5
2 0040 0002abc 7e81 000abc81 000abd7e
2 0040 0001ffe 00ff 001ffeff 001fff00
5 0000 0000200 1111 00000001 00000000
4 0000 0012340 c0de 00012340 0000c0de
ff 0000 0000000 0000 00000000 00000000

//--- src.f
common/cdi_load_pkg.sv
common/cdi_mem_pkg.sv
design/loader/image_router.sv
design/loader/rom_write_latch.sv
design/core_reset_gen.sv
design/sdram_prep_arbiter.sv
design/cdi_loader_top.sv
testbench/tb_cdi_loader_assertions.sv
testbench/tb_checker.sv
testbench/tb_cdi_loader.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f src.f --top-module tb_cdi_loader -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
